/* run.sh */
#!/usr/bin/env bash
# build the mmu testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_mmu -o tb_mmu

# a failing run ends in $fatal and gives a nonzero exit status
./obj_dir/tb_mmu

/* src.f */
src/mmu_pkg.sv
src/mmu_tlb.sv
src/mmu_ptw.sv
src/mmu_lsu_stage.sv
src/mmu_top.sv
testbench/pt_mem_model.sv
testbench/tb_mmu.sv

/* src/mmu_lsu_stage.sv */
`timescale 1ns/1ns

module mmu_lsu_stage (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      en_translation_i,
  input  mmu_pkg::priv_lvl_e        priv_lvl_i,
  input  logic                      sum_i,
  input  logic                      mxr_i,
  input  logic                      lsu_req_i,
  input  logic [mmu_pkg::VLEN-1:0]  lsu_vaddr_i,
  input  logic                      lsu_is_store_i,
  input  logic                      tlb_hit_i,
  input  logic [mmu_pkg::PTE_W-1:0] tlb_pte_i,
  input  mmu_pkg::page_size_e       tlb_size_i,
  input  logic                      ptw_error_i,
  input  logic [mmu_pkg::VLEN-1:0]  bad_vaddr_i,
  output logic                      lsu_valid_o,
  output logic [mmu_pkg::PLEN-1:0]  lsu_paddr_o,
  output logic                      lsu_exception_valid_o,
  output mmu_pkg::exc_cause_e       lsu_exception_cause_o,
  output logic [mmu_pkg::VLEN-1:0]  lsu_exception_tval_o
);

  logic                      req_q;
  logic                      hit_q;
  logic [mmu_pkg::VLEN-1:0]  vaddr_q;
  logic                      is_store_q;
  logic [mmu_pkg::PTE_W-1:0] pte_q;
  mmu_pkg::page_size_e       size_q;

  logic hit_done;
  logic page_fault;

  // ------------------------------
  // request registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
      hit_q <= 1'b0;
    end else begin
      // a request already answered this cycle is not taken again
      req_q <= lsu_req_i && !lsu_valid_o;
      hit_q <= tlb_hit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    vaddr_q    <= lsu_vaddr_i;
    is_store_q <= lsu_is_store_i;
    pte_q      <= tlb_pte_i;
    size_q     <= tlb_size_i;
  end

  // ------------------------------
  // address composition
  // ------------------------------
  always_comb begin
    if (!en_translation_i) begin
      // bare mode, zero extended vaddr
      lsu_paddr_o = {{(mmu_pkg::PLEN - mmu_pkg::VLEN){1'b0}}, vaddr_q};
    end else begin
      lsu_paddr_o = {pte_q[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::PPNW],
                     vaddr_q[mmu_pkg::PAGE_OFFSET_W-1:0]};
      // megapage keeps vpn[0]
      if (size_q == mmu_pkg::PAGE_2M) begin
        lsu_paddr_o[20:12] = vaddr_q[20:12];
      end
      // gigapage keeps vpn[1] and vpn[0]
      if (size_q == mmu_pkg::PAGE_1G) begin
        lsu_paddr_o[29:12] = vaddr_q[29:12];
      end
    end
  end

  // ------------------------------
  // permission check
  // ------------------------------
  always_comb begin
    page_fault = 1'b0;
    // no hardware a/d update, a clear A always faults
    if (!pte_q[mmu_pkg::PTE_A]) begin
      page_fault = 1'b1;
    end
    if (is_store_q) begin
      // stores need W and an already dirty page
      if (!pte_q[mmu_pkg::PTE_W_BIT] || !pte_q[mmu_pkg::PTE_D]) begin
        page_fault = 1'b1;
      end
    end else if (!pte_q[mmu_pkg::PTE_R] && !(pte_q[mmu_pkg::PTE_X] && mxr_i)) begin
      // execute-only pages are readable under mxr
      page_fault = 1'b1;
    end
    // user page from supervisor needs sum
    if ((priv_lvl_i == mmu_pkg::PRIV_S) && pte_q[mmu_pkg::PTE_U] && !sum_i) begin
      page_fault = 1'b1;
    end
    // user mode only reaches user pages
    if ((priv_lvl_i == mmu_pkg::PRIV_U) && !pte_q[mmu_pkg::PTE_U]) begin
      page_fault = 1'b1;
    end
  end

  // ------------------------------
  // response
  // ------------------------------
  assign hit_done = req_q && en_translation_i && hit_q;

  // bare mode and hits answer one cycle after sampling
  // a walk error answers in the cycle of the pulse
  assign lsu_valid_o = (req_q && (!en_translation_i || hit_q)) || ptw_error_i;

  assign lsu_exception_valid_o = (hit_done && page_fault) || ptw_error_i;
  assign lsu_exception_cause_o = is_store_q ? mmu_pkg::STORE_PAGE_FAULT
                                            : mmu_pkg::LOAD_PAGE_FAULT;
  // walker reports the vaddr it latched
  assign lsu_exception_tval_o  = ptw_error_i ? bad_vaddr_i : vaddr_q;

endmodule

/* src/mmu_pkg.sv */
package mmu_pkg;

  // ------------------------------
  // address widths, sv39
  // ------------------------------
  localparam int unsigned VLEN          = 39;
  localparam int unsigned PLEN          = 56;
  localparam int unsigned PPNW          = 44;
  localparam int unsigned PAGE_OFFSET_W = 12;
  // one vpn slice, three slices make up the full vpn
  localparam int unsigned VPN_W         = 9;
  localparam int unsigned LEVELS        = 3;
  localparam int unsigned PTE_W         = 64;

  // default data tlb depth
  localparam int unsigned DTLB_ENTRIES = 4;

  // ------------------------------
  // pte flag bit positions
  // ------------------------------
  localparam int unsigned PTE_V       = 0;
  localparam int unsigned PTE_R       = 1;
  localparam int unsigned PTE_W_BIT   = 2;
  localparam int unsigned PTE_X       = 3;
  localparam int unsigned PTE_U       = 4;
  localparam int unsigned PTE_A       = 6;
  localparam int unsigned PTE_D       = 7;
  // ppn field starts above the rsw bits
  localparam int unsigned PTE_PPN_LSB = 10;

  // privilege level as seen by loads and stores
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // mcause codes, only the page faults are raised here
  typedef enum logic [3:0] {
    LOAD_PAGE_FAULT  = 4'd13,
    STORE_PAGE_FAULT = 4'd15
  } exc_cause_e;

  // leaf size, follows the level the walk stopped at
  typedef enum logic [1:0] {
    PAGE_4K = 2'd0,
    PAGE_2M = 2'd1,
    PAGE_1G = 2'd2
  } page_size_e;

  typedef enum logic [1:0] {
    PTW_IDLE,
    PTW_REQ,
    PTW_WAIT_ACK_LOW,
    PTW_ERROR
  } ptw_state_e;

endpackage

/* src/mmu_ptw.sv */
`timescale 1ns/1ns

module mmu_ptw (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      flush_i,
  input  logic                                      en_translation_i,
  input  logic                                      lsu_req_i,
  input  logic [mmu_pkg::VLEN-1:0]                  lsu_vaddr_i,
  input  logic                                      tlb_hit_i,
  input  logic [mmu_pkg::PPNW-1:0]                  satp_ppn_i,
  input  logic                                      mem_ack_i,
  input  logic [mmu_pkg::PTE_W-1:0]                 mem_rdata_i,
  output logic                                      ptw_active_o,
  output logic                                      mem_req_o,
  output logic [mmu_pkg::PLEN-1:0]                  mem_addr_o,
  output logic                                      update_valid_o,
  output logic [mmu_pkg::LEVELS*mmu_pkg::VPN_W-1:0] update_vpn_o,
  output logic [mmu_pkg::PTE_W-1:0]                 update_pte_o,
  output mmu_pkg::page_size_e                       update_size_o,
  output logic                                      ptw_error_o,
  output logic [mmu_pkg::VLEN-1:0]                  bad_vaddr_o
);

  mmu_pkg::ptw_state_e state_q, state_d;
  logic [1:0] lvl_q, lvl_d;
  logic stale_q, stale_d;
  logic start;

  // walk payload
  logic [mmu_pkg::VLEN-1:0]  vaddr_q;
  logic [mmu_pkg::PPNW-1:0]  ppn_q, ppn_d;
  logic [mmu_pkg::PTE_W-1:0] pte_q;

  // pte decode
  logic pte_leaf;
  logic pte_invalid;
  logic pte_misaligned;
  logic walk_err;

  // miss on a translated request while nothing is in flight
  assign start = (state_q == mmu_pkg::PTW_IDLE) && lsu_req_i && en_translation_i && !tlb_hit_i;

  assign pte_leaf    = pte_q[mmu_pkg::PTE_R] || pte_q[mmu_pkg::PTE_X];
  // invalid, or the reserved w without r combination
  assign pte_invalid = !pte_q[mmu_pkg::PTE_V] ||
                       (pte_q[mmu_pkg::PTE_W_BIT] && !pte_q[mmu_pkg::PTE_R]);
  // superpage leaves need their low ppn slices clear
  assign pte_misaligned =
    ((lvl_q == 2'd2) && (|pte_q[mmu_pkg::PTE_PPN_LSB +: 2*mmu_pkg::VPN_W])) ||
    ((lvl_q == 2'd1) && (|pte_q[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::VPN_W]));
  // a pointer at level 0 has nowhere to go
  assign walk_err = pte_invalid || (!pte_leaf && (lvl_q == 2'd0)) ||
                    (pte_leaf && pte_misaligned);

  // table ppn, vpn slice of this level, 8 byte entries
  assign mem_addr_o = {ppn_q,
                       vaddr_q[mmu_pkg::PAGE_OFFSET_W + lvl_q*mmu_pkg::VPN_W +: mmu_pkg::VPN_W],
                       3'b000};

  assign ptw_active_o = (state_q != mmu_pkg::PTW_IDLE);
  assign bad_vaddr_o  = vaddr_q;
  assign update_vpn_o = vaddr_q[mmu_pkg::VLEN-1:mmu_pkg::PAGE_OFFSET_W];
  assign update_pte_o = pte_q;

  // leaf size comes from where the walk stopped
  always_comb begin
    case (lvl_q)
      2'd2:    update_size_o = mmu_pkg::PAGE_1G;
      2'd1:    update_size_o = mmu_pkg::PAGE_2M;
      default: update_size_o = mmu_pkg::PAGE_4K;
    endcase
  end

  // ------------------------------
  // walker fsm
  // ------------------------------
  always_comb begin
    state_d        = state_q;
    lvl_d          = lvl_q;
    ppn_d          = ppn_q;
    stale_d        = stale_q;
    mem_req_o      = 1'b0;
    update_valid_o = 1'b0;
    ptw_error_o    = 1'b0;

    // a flush mid walk poisons the refill
    if (flush_i && (state_q != mmu_pkg::PTW_IDLE)) begin
      stale_d = 1'b1;
    end

    case (state_q)
      mmu_pkg::PTW_IDLE: begin
        if (start) begin
          state_d = mmu_pkg::PTW_REQ;
          lvl_d   = 2'(mmu_pkg::LEVELS - 1);
          ppn_d   = satp_ppn_i;
          stale_d = 1'b0;
        end
      end
      mmu_pkg::PTW_REQ: begin
        // hold req with a stable address until ack
        mem_req_o = 1'b1;
        if (mem_ack_i) begin
          state_d = mmu_pkg::PTW_WAIT_ACK_LOW;
        end
      end
      mmu_pkg::PTW_WAIT_ACK_LOW: begin
        // four phase, the next step waits for ack to drop
        if (!mem_ack_i) begin
          if (walk_err) begin
            state_d = mmu_pkg::PTW_ERROR;
          end else if (pte_leaf) begin
            update_valid_o = !stale_q;
            state_d        = mmu_pkg::PTW_IDLE;
          end else begin
            // descend into the next table
            ppn_d   = pte_q[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::PPNW];
            lvl_d   = lvl_q - 2'd1;
            state_d = mmu_pkg::PTW_REQ;
          end
        end
      end
      mmu_pkg::PTW_ERROR: begin
        // one cycle pulse, lsu stage turns it into a page fault
        ptw_error_o = 1'b1;
        state_d     = mmu_pkg::PTW_IDLE;
      end
      default: begin
        state_d = mmu_pkg::PTW_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= mmu_pkg::PTW_IDLE;
      lvl_q   <= '0;
      stale_q <= 1'b0;
    end else begin
      state_q <= state_d;
      lvl_q   <= lvl_d;
      stale_q <= stale_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ppn_q <= ppn_d;
    // vaddr latched once per walk
    if (start) begin
      vaddr_q <= lsu_vaddr_i;
    end
    // capture the pte on the ack edge
    if ((state_q == mmu_pkg::PTW_REQ) && mem_ack_i) begin
      pte_q <= mem_rdata_i;
    end
  end

endmodule

/* src/mmu_tlb.sv */
`timescale 1ns/1ns

module mmu_tlb #(
  parameter int unsigned nr_entries = mmu_pkg::DTLB_ENTRIES
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        flush_i,
  input  logic [mmu_pkg::VLEN-1:0]                    lu_vaddr_i,
  input  logic                                        update_valid_i,
  input  logic [mmu_pkg::LEVELS*mmu_pkg::VPN_W-1:0]   update_vpn_i,
  input  logic [mmu_pkg::PTE_W-1:0]                   update_pte_i,
  input  mmu_pkg::page_size_e                         update_size_i,
  output logic                                        lu_hit_o,
  output logic [mmu_pkg::PTE_W-1:0]                   lu_pte_o,
  output mmu_pkg::page_size_e                         lu_size_o
);

  // entry storage
  logic                                      valid_q [nr_entries];
  logic [mmu_pkg::LEVELS*mmu_pkg::VPN_W-1:0] vpn_q   [nr_entries];
  logic [mmu_pkg::PTE_W-1:0]                 pte_q   [nr_entries];
  mmu_pkg::page_size_e                       size_q  [nr_entries];

  // next entry to replace
  logic [$clog2(nr_entries)-1:0] rr_q;

  logic [mmu_pkg::LEVELS*mmu_pkg::VPN_W-1:0] lu_vpn;
  logic [nr_entries-1:0]                     match;
  logic                                      refill;

  assign lu_vpn = lu_vaddr_i[mmu_pkg::VLEN-1:mmu_pkg::PAGE_OFFSET_W];
  // a flush wins over a refill landing in the same cycle
  assign refill = update_valid_i && !flush_i;

  // ------------------------------
  // lookup
  // ------------------------------
  always_comb begin
    for (int i = 0; i < nr_entries; i++) begin
      // top slice always compared
      match[i] = valid_q[i] &&
                 (vpn_q[i][2*mmu_pkg::VPN_W +: mmu_pkg::VPN_W] ==
                  lu_vpn[2*mmu_pkg::VPN_W +: mmu_pkg::VPN_W]);
      // middle slice ignored for gigapages
      if (size_q[i] != mmu_pkg::PAGE_1G) begin
        match[i] = match[i] &&
                   (vpn_q[i][mmu_pkg::VPN_W +: mmu_pkg::VPN_W] ==
                    lu_vpn[mmu_pkg::VPN_W +: mmu_pkg::VPN_W]);
      end
      // lowest slice only for 4k pages
      if (size_q[i] == mmu_pkg::PAGE_4K) begin
        match[i] = match[i] &&
                   (vpn_q[i][mmu_pkg::VPN_W-1:0] == lu_vpn[mmu_pkg::VPN_W-1:0]);
      end
    end
  end

  // first matching entry drives the outputs
  always_comb begin
    lu_hit_o  = 1'b0;
    lu_pte_o  = '0;
    lu_size_o = mmu_pkg::PAGE_4K;
    for (int i = 0; i < nr_entries; i++) begin
      if (match[i] && !lu_hit_o) begin
        lu_hit_o  = 1'b1;
        lu_pte_o  = pte_q[i];
        lu_size_o = size_q[i];
      end
    end
  end

  // ------------------------------
  // refill and flush
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
      for (int i = 0; i < nr_entries; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (flush_i) begin
      for (int i = 0; i < nr_entries; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (refill) begin
      valid_q[rr_q] <= 1'b1;
      // round robin, wraps also for a non power of two depth
      if (int'(rr_q) == nr_entries - 1) begin
        rr_q <= '0;
      end else begin
        rr_q <= rr_q + 1'b1;
      end
    end
  end

  // tag and leaf payload
  always_ff @(posedge clk_i) begin
    if (refill) begin
      vpn_q[rr_q]  <= update_vpn_i;
      pte_q[rr_q]  <= update_pte_i;
      size_q[rr_q] <= update_size_i;
    end
  end

endmodule

/* src/mmu_top.sv */
`timescale 1ns/1ns

module mmu_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // control
  input  logic                      en_translation_i,
  input  mmu_pkg::priv_lvl_e        priv_lvl_i,
  input  logic                      sum_i,
  input  logic                      mxr_i,
  input  logic [mmu_pkg::PPNW-1:0]  satp_ppn_i,
  input  logic                      flush_tlb_i,
  // load/store request and response
  input  logic                      lsu_req_i,
  input  logic [mmu_pkg::VLEN-1:0]  lsu_vaddr_i,
  input  logic                      lsu_is_store_i,
  output logic                      lsu_valid_o,
  output logic [mmu_pkg::PLEN-1:0]  lsu_paddr_o,
  output logic                      lsu_exception_valid_o,
  output mmu_pkg::exc_cause_e       lsu_exception_cause_o,
  output logic [mmu_pkg::VLEN-1:0]  lsu_exception_tval_o,
  // page table memory, four phase req/ack
  output logic                      mem_req_o,
  output logic [mmu_pkg::PLEN-1:0]  mem_addr_o,
  input  logic                      mem_ack_i,
  input  logic [mmu_pkg::PTE_W-1:0] mem_rdata_i
);

  // tlb lookup result
  logic                      tlb_hit;
  logic [mmu_pkg::PTE_W-1:0] tlb_pte;
  mmu_pkg::page_size_e       tlb_size;

  // walker refill
  logic                                      update_valid;
  logic [mmu_pkg::LEVELS*mmu_pkg::VPN_W-1:0] update_vpn;
  logic [mmu_pkg::PTE_W-1:0]                 update_pte;
  mmu_pkg::page_size_e                       update_size;

  // walker error
  logic                     ptw_error;
  logic [mmu_pkg::VLEN-1:0] bad_vaddr;

  mmu_tlb #(
    .nr_entries(mmu_pkg::DTLB_ENTRIES)
  ) i_dtlb (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_tlb_i),
    .lu_vaddr_i    (lsu_vaddr_i),
    .update_valid_i(update_valid),
    .update_vpn_i  (update_vpn),
    .update_pte_i  (update_pte),
    .update_size_i (update_size),
    .lu_hit_o      (tlb_hit),
    .lu_pte_o      (tlb_pte),
    .lu_size_o     (tlb_size)
  );

  // busy flag has no consumer with a single client
  mmu_ptw i_ptw (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_tlb_i),
    .en_translation_i(en_translation_i),
    .lsu_req_i       (lsu_req_i),
    .lsu_vaddr_i     (lsu_vaddr_i),
    .tlb_hit_i       (tlb_hit),
    .satp_ppn_i      (satp_ppn_i),
    .mem_ack_i       (mem_ack_i),
    .mem_rdata_i     (mem_rdata_i),
    .ptw_active_o    (),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .update_valid_o  (update_valid),
    .update_vpn_o    (update_vpn),
    .update_pte_o    (update_pte),
    .update_size_o   (update_size),
    .ptw_error_o     (ptw_error),
    .bad_vaddr_o     (bad_vaddr)
  );

  mmu_lsu_stage i_lsu_stage (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .en_translation_i     (en_translation_i),
    .priv_lvl_i           (priv_lvl_i),
    .sum_i                (sum_i),
    .mxr_i                (mxr_i),
    .lsu_req_i            (lsu_req_i),
    .lsu_vaddr_i          (lsu_vaddr_i),
    .lsu_is_store_i       (lsu_is_store_i),
    .tlb_hit_i            (tlb_hit),
    .tlb_pte_i            (tlb_pte),
    .tlb_size_i           (tlb_size),
    .ptw_error_i          (ptw_error),
    .bad_vaddr_i          (bad_vaddr),
    .lsu_valid_o          (lsu_valid_o),
    .lsu_paddr_o          (lsu_paddr_o),
    .lsu_exception_valid_o(lsu_exception_valid_o),
    .lsu_exception_cause_o(lsu_exception_cause_o),
    .lsu_exception_tval_o (lsu_exception_tval_o)
  );

endmodule

/* testbench/pt_mem_model.sv */
`timescale 1ns/1ns

module pt_mem_model (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      mem_req_i,
  input  logic [mmu_pkg::PLEN-1:0]  mem_addr_i,
  output logic                      mem_ack_o,
  output logic [mmu_pkg::PTE_W-1:0] mem_rdata_o,
  output int unsigned               req_count_o
);

  // sparse page table
  // words never written read back as zero, an invalid pte
  logic [mmu_pkg::PTE_W-1:0] pt_words [logic [mmu_pkg::PLEN-1:0]];

  task automatic write_pte(input logic [mmu_pkg::PLEN-1:0] addr,
                           input logic [mmu_pkg::PTE_W-1:0] pte);
    pt_words[addr] = pte;
  endtask

  // ------------------------------
  // four phase responder
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_ack_o   <= 1'b0;
      mem_rdata_o <= '0;
      req_count_o <= 0;
    end else if (mem_req_i && !mem_ack_o) begin
      // ack one cycle after req, data valid with it
      mem_ack_o   <= 1'b1;
      mem_rdata_o <= pt_words.exists(mem_addr_i) ? pt_words[mem_addr_i] : '0;
      req_count_o <= req_count_o + 1;
    end else if (!mem_req_i) begin
      // ack follows req back to low
      mem_ack_o <= 1'b0;
    end
  end

endmodule

/* testbench/tb_mmu.sv */
`timescale 1ns/1ns

module tb_mmu;

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        en_translation;
  mmu_pkg::priv_lvl_e          priv_lvl;
  logic                        sum_on;
  logic                        mxr_on;
  logic [mmu_pkg::PPNW-1:0]    satp_ppn;
  logic                        flush_tlb;
  logic                        lsu_req;
  logic [mmu_pkg::VLEN-1:0]    lsu_vaddr;
  logic                        lsu_is_store;
  logic                        lsu_valid;
  logic [mmu_pkg::PLEN-1:0]    lsu_paddr;
  logic                        lsu_exc_valid;
  mmu_pkg::exc_cause_e         lsu_exc_cause;
  logic [mmu_pkg::VLEN-1:0]    lsu_exc_tval;
  logic                        mem_req;
  logic [mmu_pkg::PLEN-1:0]    mem_addr;
  logic                        mem_ack;
  logic [mmu_pkg::PTE_W-1:0]   mem_rdata;
  int unsigned                 mem_count;

  // response of the last access
  int unsigned                 latency;
  int unsigned                 walk_reqs;
  logic [mmu_pkg::PLEN-1:0]    got_paddr;
  logic                        got_exc;
  mmu_pkg::exc_cause_e         got_cause;
  logic [mmu_pkg::VLEN-1:0]    got_tval;

  logic [31:0]                 rng = 32'd16;
  int unsigned                 cycle_count = 0;

  // 8 ns period
  always #4 clk = ~clk;

  mmu_top dut_i (
    .clk_i                (clk),
    .rst_ni               (rst_n),
    .en_translation_i     (en_translation),
    .priv_lvl_i           (priv_lvl),
    .sum_i                (sum_on),
    .mxr_i                (mxr_on),
    .satp_ppn_i           (satp_ppn),
    .flush_tlb_i          (flush_tlb),
    .lsu_req_i            (lsu_req),
    .lsu_vaddr_i          (lsu_vaddr),
    .lsu_is_store_i       (lsu_is_store),
    .lsu_valid_o          (lsu_valid),
    .lsu_paddr_o          (lsu_paddr),
    .lsu_exception_valid_o(lsu_exc_valid),
    .lsu_exception_cause_o(lsu_exc_cause),
    .lsu_exception_tval_o (lsu_exc_tval),
    .mem_req_o            (mem_req),
    .mem_addr_o           (mem_addr),
    .mem_ack_i            (mem_ack),
    .mem_rdata_i          (mem_rdata)
  );

  pt_mem_model pt_mem_i (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .mem_req_i  (mem_req),
    .mem_addr_i (mem_addr),
    .mem_ack_o  (mem_ack),
    .mem_rdata_o(mem_rdata),
    .req_count_o(mem_count)
  );

  // ------------------------------
  // protocol assertions
  // ------------------------------
  // next request only once ack has dropped
  req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(mem_req) |-> !mem_ack)
  else begin
    $display("test failed");
    $fatal(1, "memory request raised while ack was still high");
  end

  // address held until the memory answers
  addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req && !mem_ack |=> $stable(mem_addr))
  else begin
    $display("test failed");
    $fatal(1, "memory address changed while the request waited for ack");
  end

  exc_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_exc_valid |-> lsu_valid)
  else begin
    $display("test failed");
    $fatal(1, "exception raised without a valid response");
  end

  // about 20 accesses of up to 20 cycles plus reset stay far below this
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= 4000) begin
      $display("test failed");
      $fatal(1, "timeout after 4000 cycles without finishing the tests");
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // sv39 pte from a ppn and a flag string such as "vrwad"
  function automatic logic [mmu_pkg::PTE_W-1:0] make_pte(input logic [43:0] ppn,
                                                         input string flags);
    logic [7:0] f;
    f = '0;
    for (int i = 0; i < flags.len(); i++) begin
      case (flags[i])
        "v": f[mmu_pkg::PTE_V] = 1'b1;
        "r": f[mmu_pkg::PTE_R] = 1'b1;
        "w": f[mmu_pkg::PTE_W_BIT] = 1'b1;
        "x": f[mmu_pkg::PTE_X] = 1'b1;
        "u": f[mmu_pkg::PTE_U] = 1'b1;
        "a": f[mmu_pkg::PTE_A] = 1'b1;
        "d": f[mmu_pkg::PTE_D] = 1'b1;
        default: begin
        end
      endcase
    end
    return {10'b0, ppn, 2'b00, f};
  endfunction

  // 8 byte entry inside a 4k table
  function automatic logic [mmu_pkg::PLEN-1:0] pt_addr(input logic [43:0] ppn,
                                                       input logic [8:0] idx);
    return {ppn, idx, 3'b000};
  endfunction

  task automatic check_equal(input string test, input string field,
                             input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("test failed");
      $fatal(1, "Error: %s %s expected 0x%0h actual 0x%0h", test, field, exp, act);
    end
  endtask

  // root 0x80000, level 1 table 0x80001, level 0 table 0x80002
  task automatic build_tables();
    pt_mem_i.write_pte(pt_addr(44'h80000, 9'd1), make_pte(44'h80001, "v"));
    pt_mem_i.write_pte(pt_addr(44'h80000, 9'd2), make_pte(44'hc0000, "vra"));
    pt_mem_i.write_pte(pt_addr(44'h80001, 9'd0), make_pte(44'h80002, "v"));
    pt_mem_i.write_pte(pt_addr(44'h80001, 9'd3), make_pte(44'h40200, "vrwad"));
    // vpn1 4 stays empty for the walk error
    pt_mem_i.write_pte(pt_addr(44'h80002, 9'd5), make_pte(44'h12345, "vrwad"));
    pt_mem_i.write_pte(pt_addr(44'h80002, 9'd6), make_pte(44'h12346, "vrad"));
    pt_mem_i.write_pte(pt_addr(44'h80002, 9'd7), make_pte(44'h12347, "vrwa"));
    pt_mem_i.write_pte(pt_addr(44'h80002, 9'd8), make_pte(44'h12348, "vrwadu"));
    pt_mem_i.write_pte(pt_addr(44'h80002, 9'd9), make_pte(44'h12349, "vxa"));
  endtask

  // hold the request until valid, then release it for one idle cycle
  task automatic run_access(input logic [mmu_pkg::VLEN-1:0] va, input logic is_store);
    int unsigned count_before;
    count_before = mem_count;
    lsu_req      = 1'b1;
    lsu_vaddr    = va;
    lsu_is_store = is_store;
    latency      = 0;
    @(negedge clk);
    while (!lsu_valid) begin
      @(negedge clk);
      latency++;
    end
    got_paddr = lsu_paddr;
    got_exc   = lsu_exc_valid;
    got_cause = lsu_exc_cause;
    got_tval  = lsu_exc_tval;
    walk_reqs = mem_count - count_before;
    @(posedge clk);
    #1;
    lsu_req = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic expect_ok(input string test, input logic [mmu_pkg::PLEN-1:0] exp_paddr,
                           input int unsigned exp_reqs);
    check_equal(test, "exception", 64'd0, 64'(got_exc));
    check_equal(test, "paddr", 64'(exp_paddr), 64'(got_paddr));
    check_equal(test, "walk requests", 64'(exp_reqs), 64'(walk_reqs));
  endtask

  task automatic expect_fault(input string test, input mmu_pkg::exc_cause_e cause,
                              input logic [mmu_pkg::VLEN-1:0] tval,
                              input int unsigned exp_reqs);
    check_equal(test, "exception", 64'd1, 64'(got_exc));
    check_equal(test, "cause", 64'(cause), 64'(got_cause));
    check_equal(test, "tval", 64'(tval), 64'(got_tval));
    check_equal(test, "walk requests", 64'(exp_reqs), 64'(walk_reqs));
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    logic [mmu_pkg::VLEN-1:0] va;
    logic [11:0]              off;
    rst_n          = 1'b0;
    en_translation = 1'b0;
    priv_lvl       = mmu_pkg::PRIV_S;
    sum_on         = 1'b0;
    mxr_on         = 1'b0;
    satp_ppn       = 44'h80000;
    flush_tlb      = 1'b0;
    lsu_req        = 1'b0;
    lsu_vaddr      = '0;
    lsu_is_store   = 1'b0;
    build_tables();
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    assert (!lsu_valid && !lsu_exc_valid && !mem_req) else begin
      $display("test failed");
      $fatal(1, "valid, exception or memory request not low after reset");
    end
    @(posedge clk);
    #1;

    // bare mode pass-through
    rng = xorshift32(rng);
    va[31:0] = rng;
    rng = xorshift32(rng);
    va[38:32] = rng[6:0];
    run_access(va, 1'b0);
    check_equal("bare", "latency", 64'd1, 64'(latency));
    expect_ok("bare", {17'b0, va}, 0);

    // 4k leaf, full walk then hit
    en_translation = 1'b1;
    rng = xorshift32(rng);
    off = rng[11:0];
    run_access({9'd1, 9'd0, 9'd5, off}, 1'b0);
    expect_ok("4k walk", {44'h12345, off}, 3);
    rng = xorshift32(rng);
    off = rng[11:0];
    run_access({9'd1, 9'd0, 9'd5, off}, 1'b0);
    check_equal("4k hit", "latency", 64'd1, 64'(latency));
    expect_ok("4k hit", {44'h12345, off}, 0);

    // superpages keep the low vpn slices of the vaddr
    rng = xorshift32(rng);
    va = {9'd1, 9'd3, rng[20:0]};
    run_access(va, 1'b0);
    expect_ok("2m leaf", {35'h201, va[20:0]}, 2);
    rng = xorshift32(rng);
    va = {9'd2, rng[29:0]};
    run_access(va, 1'b0);
    expect_ok("1g leaf", {26'h3, va[29:0]}, 1);

    // stores to pages without W or without D
    rng = xorshift32(rng);
    va = {9'd1, 9'd0, 9'd6, rng[11:0]};
    run_access(va, 1'b1);
    expect_fault("store no w", mmu_pkg::STORE_PAGE_FAULT, va, 3);
    rng = xorshift32(rng);
    va = {9'd1, 9'd0, 9'd7, rng[11:0]};
    run_access(va, 1'b1);
    expect_fault("store no d", mmu_pkg::STORE_PAGE_FAULT, va, 3);

    // user page from s-mode
    rng = xorshift32(rng);
    off = rng[11:0];
    va = {9'd1, 9'd0, 9'd8, off};
    run_access(va, 1'b0);
    expect_fault("u page no sum", mmu_pkg::LOAD_PAGE_FAULT, va, 3);
    sum_on = 1'b1;
    run_access(va, 1'b0);
    expect_ok("u page sum", {44'h12348, off}, 0);
    sum_on = 1'b0;

    // execute-only page is readable only with mxr
    rng = xorshift32(rng);
    off = rng[11:0];
    va = {9'd1, 9'd0, 9'd9, off};
    run_access(va, 1'b0);
    expect_fault("x page no mxr", mmu_pkg::LOAD_PAGE_FAULT, va, 3);
    mxr_on = 1'b1;
    run_access(va, 1'b0);
    expect_ok("x page mxr", {44'h12349, off}, 0);
    mxr_on = 1'b0;

    // invalid pte at level 1, nothing may land in the tlb
    rng = xorshift32(rng);
    va = {9'd1, 9'd4, rng[20:0]};
    run_access(va, 1'b0);
    expect_fault("walk error", mmu_pkg::LOAD_PAGE_FAULT, va, 2);
    run_access(va, 1'b0);
    expect_fault("walk error again", mmu_pkg::LOAD_PAGE_FAULT, va, 2);

    // flush drops a hitting page
    // the 4k page was evicted by round robin, so it walks first
    rng = xorshift32(rng);
    off = rng[11:0];
    va = {9'd1, 9'd0, 9'd5, off};
    run_access(va, 1'b0);
    expect_ok("flush refill", {44'h12345, off}, 3);
    run_access(va, 1'b0);
    expect_ok("flush before", {44'h12345, off}, 0);
    flush_tlb = 1'b1;
    @(posedge clk);
    #1;
    flush_tlb = 1'b0;
    run_access(va, 1'b0);
    expect_ok("flush after", {44'h12345, off}, 3);

    $display("test passed");
    $finish;
  end

endmodule
